/* src/rv_core_pkg.sv */
package rv_core_pkg;

  // data word, byte address or instruction
  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_index_t;

  // ALU operations; the last six are the branch comparisons
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_eq,
    alu_ne,
    alu_lt,
    alu_ge,
    alu_ltu,
    alu_geu
  } alu_op_t;

  // writeback source
  typedef enum logic [1:0] {
    res_alu,
    res_link,
    res_pc_imm,
    res_load
  } result_sel_t;

  typedef enum logic [1:0] {
    arb_idle,
    arb_setup,
    arb_access
  } arb_state_t;

  typedef enum logic [1:0] {
    fetch_request,
    fetch_wait,
    fetch_hold
  } fetch_state_t;

endpackage

/* src/register_file.sv */
`timescale 1ns/1ps

module register_file (
  input  logic                    clock,
  input  rv_core_pkg::reg_index_t rs1,
  input  rv_core_pkg::reg_index_t rs2,
  input  logic                    wen,
  input  rv_core_pkg::reg_index_t wd_index,
  input  rv_core_pkg::word_t      wdata,
  output rv_core_pkg::word_t      rdata1,
  output rv_core_pkg::word_t      rdata2
);
  import rv_core_pkg::*;

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clock) begin
    if (wen && wd_index != '0) begin
      regs[wd_index] <= wdata;
    end
  end

  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
  parameter rv_core_pkg::word_t reset_pc = '0
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               fetch_ready,
  input  rv_core_pkg::word_t fetch_rdata,
  input  logic               idu_ready,
  input  logic               redirect,
  input  rv_core_pkg::word_t redirect_pc,
  output logic               fetch_req,
  output rv_core_pkg::word_t fetch_addr,
  output logic               inst_valid,
  output rv_core_pkg::word_t inst,
  output rv_core_pkg::word_t inst_pc
);
  import rv_core_pkg::*;

  fetch_state_t state;
  word_t pc;
  // target of a redirect seen while a fetch was still in flight
  word_t resume_pc;
  logic discard;

  // the request state lasts one cycle, the arbiter cannot answer sooner
  assign fetch_req = (state == fetch_request) || (state == fetch_wait);
  assign fetch_addr = pc;
  assign inst_valid = state == fetch_hold;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= fetch_request;
      pc <= reset_pc;
      discard <= 1'b0;
    end else begin
      case (state)
        fetch_request, fetch_wait: begin
          if (fetch_ready) begin
            discard <= 1'b0;
            // a stale word is thrown away and the fetch restarts at once
            state <= (discard || redirect) ? fetch_request : fetch_hold;
            if (redirect) begin
              pc <= redirect_pc;
            end else if (discard) begin
              pc <= resume_pc;
            end
          end else begin
            state <= fetch_wait;
            if (redirect) begin
              discard <= 1'b1;
            end
          end
        end
        default: begin
          if (redirect || idu_ready) begin
            state <= fetch_request;
            pc <= redirect ? redirect_pc : pc + 32'd4;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (redirect) begin
      resume_pc <= redirect_pc;
    end
    if (fetch_ready) begin
      inst <= fetch_rdata;
      inst_pc <= pc;
    end
  end

endmodule

/* src/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     inst_valid,
  input  rv_core_pkg::word_t       inst,
  input  rv_core_pkg::word_t       inst_pc,
  input  logic                     block,
  input  logic                     redirect,
  output logic                     idu_ready,
  output logic                     decode_valid,
  output rv_core_pkg::word_t       dec_pc,
  output rv_core_pkg::alu_op_t     alu_op,
  output rv_core_pkg::word_t       imm,
  output rv_core_pkg::reg_index_t  rs1,
  output rv_core_pkg::reg_index_t  rs2,
  output rv_core_pkg::reg_index_t  rd,
  output logic                     use_imm,
  output logic                     use_pc,
  output rv_core_pkg::result_sel_t result_sel,
  output logic                     r_wen,
  output logic                     mem_ren,
  output logic                     mem_wen,
  output logic                     is_branch,
  output logic                     is_jal,
  output logic                     is_jalr
);
  import rv_core_pkg::*;

  word_t inst_q;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic lui, auipc, jal, jalr, branch, load, store, op_imm, op;
  logic shift_ok, op_ok, legal;

  assign opcode = inst_q[6:0];
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];

  assign lui    = opcode == 7'b01_101_11;
  assign auipc  = opcode == 7'b00_101_11;
  assign jal    = opcode == 7'b11_011_11;
  assign jalr   = opcode == 7'b11_001_11;
  assign branch = opcode == 7'b11_000_11;
  assign load   = opcode == 7'b00_000_11;
  assign store  = opcode == 7'b01_000_11;
  assign op_imm = opcode == 7'b00_100_11;
  assign op     = opcode == 7'b01_100_11;

  // a load or store in flight still reads the held fields
  assign idu_ready = !block;

  always_ff @(posedge clock) begin
    if (reset || redirect) begin
      decode_valid <= 1'b0;
    end else if (!block) begin
      decode_valid <= inst_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (!block && inst_valid) begin
      inst_q <= inst;
      dec_pc <= inst_pc;
    end
  end

  always_comb begin
    if (lui || auipc) begin
      imm = {inst_q[31:12], 12'b0};
    end else if (jal) begin
      imm = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};
    end else if (branch) begin
      imm = {{20{inst_q[31]}}, inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
    end else if (store) begin
      imm = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
    end else begin
      imm = {{20{inst_q[31]}}, inst_q[31:20]};
    end
  end

  always_comb begin
    alu_op = alu_add;
    if (branch) begin
      case (funct3)
        3'b000:  alu_op = alu_eq;
        3'b001:  alu_op = alu_ne;
        3'b100:  alu_op = alu_lt;
        3'b101:  alu_op = alu_ge;
        3'b110:  alu_op = alu_ltu;
        default: alu_op = alu_geu;
      endcase
    end else if (op || op_imm) begin
      case (funct3)
        3'b000:  alu_op = (op && funct7[5]) ? alu_sub : alu_add;
        3'b001:  alu_op = alu_sll;
        3'b010:  alu_op = alu_slt;
        3'b011:  alu_op = alu_sltu;
        3'b100:  alu_op = alu_xor;
        3'b101:  alu_op = funct7[5] ? alu_sra : alu_srl;
        3'b110:  alu_op = alu_or;
        default: alu_op = alu_and;
      endcase
    end
  end

  // LUI reads x0 so the ALU forms 0 + imm
  assign rs1 = lui ? '0 : inst_q[19:15];
  assign rs2 = inst_q[24:20];
  assign rd = inst_q[11:7];

  assign use_imm = lui || auipc || jalr || load || store || op_imm;
  assign use_pc = auipc;
  assign result_sel = (jal || jalr) ? res_link :
                      auipc         ? res_pc_imm :
                      load          ? res_load : res_alu;
  assign r_wen = lui || auipc || jal || jalr || load || op_imm || op;
  assign mem_ren = load;
  assign mem_wen = store;
  assign is_branch = branch;
  assign is_jal = jal;
  assign is_jalr = jalr;

  assign shift_ok = (funct3 == 3'b001) ? (funct7 == 7'b0) :
                    (funct3 != 3'b101) || funct7 == 7'b0 || funct7 == 7'b0100000;
  assign op_ok = funct7 == 7'b0 ||
                 (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
  assign legal = lui || auipc || jal || (jalr && funct3 == 3'b000) ||
                 (branch && funct3[2:1] != 2'b01) ||
                 ((load || store) && funct3 == 3'b010) ||
                 (op_imm && shift_ok) || (op && op_ok);

  // fetch only ever hands over supported RV32I words
  assert property (@(posedge clock) disable iff (reset)
    inst_valid && idu_ready && !redirect |=> legal);

endmodule

/* src/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     decode_valid,
  input  rv_core_pkg::word_t       dec_pc,
  input  rv_core_pkg::alu_op_t     alu_op,
  input  rv_core_pkg::word_t       imm,
  input  rv_core_pkg::reg_index_t  rs1,
  input  rv_core_pkg::reg_index_t  rs2,
  input  rv_core_pkg::reg_index_t  rd,
  input  logic                     use_imm,
  input  logic                     use_pc,
  input  rv_core_pkg::result_sel_t result_sel,
  input  logic                     r_wen,
  input  logic                     mem_ren,
  input  logic                     mem_wen,
  input  logic                     is_branch,
  input  logic                     is_jal,
  input  logic                     is_jalr,
  input  logic                     data_ready,
  input  rv_core_pkg::word_t       data_rdata,
  output logic                     block,
  output logic                     redirect,
  output rv_core_pkg::word_t       redirect_pc,
  output logic                     data_req,
  output logic                     data_write,
  output rv_core_pkg::word_t       data_addr,
  output rv_core_pkg::word_t       data_wdata,
  output logic                     retire_valid,
  output rv_core_pkg::word_t       retire_pc,
  output rv_core_pkg::reg_index_t  retire_rd,
  output rv_core_pkg::word_t       retire_value
);
  import rv_core_pkg::*;

  word_t rdata1, rdata2, op_a, op_b, alu_result, pc_target, wb_value;
  logic is_mem, mem_busy, take, finish, wen;

  register_file i_register_file (
    .clock    (clock),
    .rs1      (rs1),
    .rs2      (rs2),
    .wen      (wen),
    .wd_index (rd),
    .wdata    (wb_value),
    .rdata1   (rdata1),
    .rdata2   (rdata2)
  );

  assign op_a = use_pc ? dec_pc : rdata1;
  assign op_b = use_imm ? imm : rdata2;

  always_comb begin
    case (alu_op)
      alu_add:  alu_result = op_a + op_b;
      alu_sub:  alu_result = op_a - op_b;
      alu_sll:  alu_result = op_a << op_b[4:0];
      alu_slt:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu: alu_result = {31'b0, op_a < op_b};
      alu_xor:  alu_result = op_a ^ op_b;
      alu_srl:  alu_result = op_a >> op_b[4:0];
      alu_sra:  alu_result = word_t'($signed(op_a) >>> op_b[4:0]);
      alu_or:   alu_result = op_a | op_b;
      alu_and:  alu_result = op_a & op_b;
      alu_eq:   alu_result = {31'b0, op_a == op_b};
      alu_ne:   alu_result = {31'b0, op_a != op_b};
      alu_lt:   alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_ge:   alu_result = {31'b0, $signed(op_a) >= $signed(op_b)};
      alu_ltu:  alu_result = {31'b0, op_a < op_b};
      default:  alu_result = {31'b0, op_a >= op_b};
    endcase
  end

  // branch and JAL target, also the AUIPC result
  assign pc_target = dec_pc + imm;

  always_comb begin
    case (result_sel)
      res_link:   wb_value = dec_pc + 32'd4;
      res_pc_imm: wb_value = pc_target;
      res_load:   wb_value = data_rdata;
      default:    wb_value = alu_result;
    endcase
  end

  assign is_mem = mem_ren || mem_wen;
  // the instruction after a redirect is on the wrong path
  assign take = decode_valid && !mem_busy && !redirect;
  assign finish = mem_busy && data_ready;
  assign wen = r_wen && ((take && !is_mem) || finish);

  // low again in the ready cycle so decode can move on
  assign block = mem_busy && !data_ready;
  assign data_req = mem_busy;
  assign data_write = mem_wen;
  assign data_addr = alu_result;
  assign data_wdata = rdata2;

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_busy <= 1'b0;
      redirect <= 1'b0;
      retire_valid <= 1'b0;
    end else begin
      redirect <= take && (is_jal || is_jalr || (is_branch && alu_result[0]));
      retire_valid <= (take && !is_mem) || finish;
      if (take && is_mem) begin
        mem_busy <= 1'b1;
      end else if (finish) begin
        mem_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      redirect_pc <= is_jalr ? {alu_result[31:1], 1'b0} : pc_target;
    end
    if ((take && !is_mem) || finish) begin
      retire_pc <= dec_pc;
      retire_rd <= r_wen ? rd : '0;
      retire_value <= r_wen ? wb_value : '0;
    end
  end

  // decode is flushed by the redirect, so no access can start right after it
  assert property (@(posedge clock) disable iff (reset)
    redirect |-> !data_req ##1 !$rose(data_req));

endmodule

/* src/apb_arbiter.sv */
`timescale 1ns/1ps

module apb_arbiter (
  input  logic               clock,
  input  logic               reset,
  input  logic               fetch_req,
  input  rv_core_pkg::word_t fetch_addr,
  input  logic               data_req,
  input  logic               data_write,
  input  rv_core_pkg::word_t data_addr,
  input  rv_core_pkg::word_t data_wdata,
  input  logic               pready,
  input  rv_core_pkg::word_t prdata,
  output logic               fetch_ready,
  output logic               data_ready,
  output rv_core_pkg::word_t rdata,
  output logic               psel,
  output logic               penable,
  output logic               pwrite,
  output rv_core_pkg::word_t paddr,
  output rv_core_pkg::word_t pwdata
);
  import rv_core_pkg::*;

  arb_state_t state;
  // set when the load/store path owns the current transfer
  logic owner_data;

  assign psel = state != arb_idle;
  assign penable = state == arb_access;
  assign fetch_ready = penable && pready && !owner_data;
  assign data_ready = penable && pready && owner_data;
  assign rdata = prdata;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= arb_idle;
      owner_data <= 1'b0;
    end else begin
      case (state)
        arb_idle: begin
          if (data_req || fetch_req) begin
            state <= arb_setup;
            // data wins a tie
            owner_data <= data_req;
          end
        end
        arb_setup: state <= arb_access;
        default: begin
          if (pready) begin
            state <= arb_idle;
          end
        end
      endcase
    end
  end

  // address and data are captured at grant and held for the whole transfer
  always_ff @(posedge clock) begin
    if (state == arb_idle) begin
      paddr <= data_req ? data_addr : fetch_addr;
      pwrite <= data_req && data_write;
      pwdata <= data_wdata;
    end
  end

  // the owner keeps its request raised until its ready pulse
  assert property (@(posedge clock) disable iff (reset)
    psel |-> (owner_data ? data_req : fetch_req));

  // bus address and direction track what the owner is still asking for
  assert property (@(posedge clock) disable iff (reset)
    psel |-> paddr == (owner_data ? data_addr : fetch_addr) &&
             pwrite == (owner_data && data_write));

endmodule

/* src/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top #(
  parameter rv_core_pkg::word_t reset_pc = '0
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    pready,
  input  rv_core_pkg::word_t      prdata,
  output logic                    psel,
  output logic                    penable,
  output logic                    pwrite,
  output rv_core_pkg::word_t      paddr,
  output rv_core_pkg::word_t      pwdata,
  output logic                    retire_valid,
  output rv_core_pkg::word_t      retire_pc,
  output rv_core_pkg::reg_index_t retire_rd,
  output rv_core_pkg::word_t      retire_value
);
  import rv_core_pkg::*;

  logic fetch_req, fetch_ready, inst_valid, idu_ready;
  word_t fetch_addr, rdata, inst, inst_pc;
  logic decode_valid, use_imm, use_pc, r_wen, mem_ren, mem_wen;
  logic is_branch, is_jal, is_jalr;
  word_t dec_pc, imm;
  alu_op_t alu_op;
  reg_index_t rs1, rs2, rd;
  result_sel_t result_sel;
  logic block, redirect, data_req, data_write, data_ready;
  word_t redirect_pc, data_addr, data_wdata;

  fetch_unit #(.reset_pc(reset_pc)) i_fetch_unit (
    .clock       (clock),
    .reset       (reset),
    .fetch_ready (fetch_ready),
    .fetch_rdata (rdata),
    .idu_ready   (idu_ready),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .inst_pc     (inst_pc)
  );

  decode_unit i_decode_unit (
    .clock (clock), .reset (reset), .inst_valid (inst_valid), .inst (inst),
    .inst_pc (inst_pc), .block (block), .redirect (redirect),
    .idu_ready (idu_ready), .decode_valid (decode_valid), .dec_pc (dec_pc),
    .alu_op (alu_op), .imm (imm), .rs1 (rs1), .rs2 (rs2), .rd (rd),
    .use_imm (use_imm), .use_pc (use_pc), .result_sel (result_sel), .r_wen (r_wen),
    .mem_ren (mem_ren), .mem_wen (mem_wen), .is_branch (is_branch),
    .is_jal (is_jal), .is_jalr (is_jalr)
  );

  execute_unit i_execute_unit (
    .clock (clock), .reset (reset), .decode_valid (decode_valid), .dec_pc (dec_pc),
    .alu_op (alu_op), .imm (imm), .rs1 (rs1), .rs2 (rs2), .rd (rd),
    .use_imm (use_imm), .use_pc (use_pc), .result_sel (result_sel), .r_wen (r_wen),
    .mem_ren (mem_ren), .mem_wen (mem_wen), .is_branch (is_branch),
    .is_jal (is_jal), .is_jalr (is_jalr), .data_ready (data_ready),
    .data_rdata (rdata), .block (block), .redirect (redirect),
    .redirect_pc (redirect_pc), .data_req (data_req), .data_write (data_write),
    .data_addr (data_addr), .data_wdata (data_wdata), .retire_valid (retire_valid),
    .retire_pc (retire_pc), .retire_rd (retire_rd), .retire_value (retire_value)
  );

  apb_arbiter i_apb_arbiter (
    .clock (clock), .reset (reset), .fetch_req (fetch_req), .fetch_addr (fetch_addr),
    .data_req (data_req), .data_write (data_write), .data_addr (data_addr),
    .data_wdata (data_wdata), .pready (pready), .prdata (prdata),
    .fetch_ready (fetch_ready), .data_ready (data_ready), .rdata (rdata),
    .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr), .pwdata (pwdata)
  );

endmodule

/* include/rv_core_model.svh */
`ifndef RV_CORE_MODEL_SVH
`define RV_CORE_MODEL_SVH

// instruction-level model state; programs are placed from address zero
rv_core_pkg::word_t model_regs [32];
rv_core_pkg::word_t model_mem [];
rv_core_pkg::word_t model_pc;

function automatic void model_init(input rv_core_pkg::word_t start_pc, input int words);
  model_pc = start_pc;
  model_mem = new[words];
  foreach (model_regs[i]) begin
    model_regs[i] = '0;
  end
endfunction

function automatic rv_core_pkg::word_t model_alu(input logic [2:0] f3, input logic alt,
                                                 input rv_core_pkg::word_t a,
                                                 input rv_core_pkg::word_t b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return {31'b0, $signed(a) < $signed(b)};
    3'b011:  return {31'b0, a < b};
    3'b100:  return a ^ b;
    3'b101:  return alt ? rv_core_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic model_taken(input logic [2:0] f3, input rv_core_pkg::word_t a,
                                     input rv_core_pkg::word_t b);
  case (f3)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return $signed(a) < $signed(b);
    3'b101:  return $signed(a) >= $signed(b);
    3'b110:  return a < b;
    default: return a >= b;
  endcase
endfunction

// runs one instruction and reports it the way the core retires it
function automatic void model_step(output rv_core_pkg::word_t pc,
                                   output rv_core_pkg::reg_index_t rd,
                                   output rv_core_pkg::word_t value);
  rv_core_pkg::word_t inst, a, b, imm_i, imm_s, imm_b, next_pc, result;
  logic writes;
  inst = model_mem[model_pc >> 2];
  a = model_regs[inst[19:15]];
  b = model_regs[inst[24:20]];
  imm_i = {{20{inst[31]}}, inst[31:20]};
  imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  next_pc = model_pc + 32'd4;
  writes = 1'b1;
  result = '0;
  case (inst[6:0])
    7'b0110111: result = {inst[31:12], 12'b0};
    7'b0010111: result = model_pc + {inst[31:12], 12'b0};
    7'b1101111: begin
      result = next_pc;
      next_pc = model_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    end
    7'b1100111: begin
      result = next_pc;
      next_pc = (a + imm_i) & ~32'd1;
    end
    7'b1100011: begin
      writes = 1'b0;
      if (model_taken(inst[14:12], a, b)) begin
        next_pc = model_pc + imm_b;
      end
    end
    7'b0000011: result = model_mem[(a + imm_i) >> 2];
    7'b0100011: begin
      writes = 1'b0;
      model_mem[(a + imm_s) >> 2] = b;
    end
    7'b0010011: result = model_alu(inst[14:12], inst[30] && inst[14:12] == 3'b101, a, imm_i);
    default:    result = model_alu(inst[14:12], inst[30], a, b);
  endcase
  pc = model_pc;
  rd = writes ? inst[11:7] : '0;
  value = writes ? result : '0;
  if (writes && rd != '0) begin
    model_regs[rd] = result;
  end
  model_pc = next_pc;
endfunction

// instruction for word idx of a count-word program, shaped by one random word
function automatic rv_core_pkg::word_t model_gen_inst(input int idx, input int count,
                                                      input rv_core_pkg::word_t rnd);
  logic [4:0] rd, r1, r2;
  logic [2:0] f3, f3b;
  logic [11:0] imm12;
  rv_core_pkg::word_t off, target;
  int span;
  rd = rnd[11:7];
  r1 = rnd[19:15];
  r2 = rnd[24:20];
  f3 = rnd[14:12];
  // first fill every register, then stop in a self loop
  if (idx < 31) begin
    return {rnd[31:20], 5'd0, 3'b000, 5'(idx + 1), 7'b0010011};
  end
  if (idx >= count - 1) begin
    return 32'h0000_006f;
  end
  span = (count - 1 - idx > 8) ? 8 : count - 1 - idx;
  off = 32'(1 + int'(rnd[31:28]) % span) * 4;
  target = 32'(idx) * 4 + off;
  f3b = (f3[2:1] == 2'b01) ? {2'b11, f3[0]} : f3;
  imm12 = (f3 == 3'b001) ? {7'b0, r2} :
          (f3 == 3'b101) ? {1'b0, rnd[30], 5'b0, r2} : rnd[31:20];
  case (rnd[3:0] % 10)
    0:       return {rnd[31:12], rd, 7'b0110111};
    1:       return {rnd[31:12], rd, 7'b0010111};
    2:       return {imm12, r1, f3, rd, 7'b0010011};
    3, 4:    return {1'b0, rnd[30] && (f3 == 3'b000 || f3 == 3'b101), 5'b0, r2, r1, f3, rd,
                     7'b0110011};
    // word addresses 0x400 to 0x7fc off x0
    5:       return {2'b01, rnd[27:20], 2'b00, 5'd0, 3'b010, rd, 7'b0000011};
    6:       return {2'b01, rnd[27:23], r2, 5'd0, 3'b010, rnd[22:20], 2'b00, 7'b0100011};
    7:       return {off[12], off[10:5], r2, r1, f3b, off[4:1], off[11], 7'b1100011};
    8:       return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    default: return {target[11:0], 5'd0, 3'b000, rd, 7'b1100111};
  endcase
endfunction

`endif

/* tests/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;
  import rv_core_pkg::*;

  localparam word_t reset_pc = 32'h0000_0000;
  localparam word_t seed = 32'h4389_160f;
  localparam int mem_words = 1024;
  localparam int program_len = 256;
  // data region 0x400 to 0x7fc
  localparam int data_first = 256;
  localparam int data_last = 511;
  localparam int retire_total = 300;
  localparam int wait_limit = 200;

  logic clock;
  logic reset;
  logic pready;
  word_t prdata;
  logic psel, penable, pwrite;
  word_t paddr, pwdata;
  logic retire_valid;
  word_t retire_pc, retire_value;
  reg_index_t retire_rd;

  word_t mem [mem_words];
  word_t lcg_state;
  logic dut_in_reset;
  logic prev_setup;
  logic pready_seen;
  word_t xfer_addr, xfer_wdata;
  logic xfer_write;
  int waits_left;
  int transfers;
  int retire_count;
  // completed APB writes, matched against stores as they retire
  word_t write_addr_q [$];
  word_t write_data_q [$];

  `include "rv_core_model.svh"

  rv_core_top #(.reset_pc(reset_pc)) i_dut (
    .clock        (clock),
    .reset        (reset),
    .pready       (pready),
    .prdata       (prdata),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_value (retire_value)
  );

  always #20 clock = ~clock;

  task automatic halt_run();
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_problem(input string reason);
    $display("%0t ns: %s", $time, reason);
    halt_run();
  endtask

  task automatic check_word(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s is 0x%h, expected 0x%h", $time, name, actual, expected);
      halt_run();
    end
  endtask

  task automatic check_index(input string name, input reg_index_t actual,
                             input reg_index_t expected);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s is x%0d, expected x%0d", $time, name, actual, expected);
      halt_run();
    end
  endtask

  task automatic check_flag(input string name, input bit actual, input bit expected);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
      halt_run();
    end
  endtask

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper halves only, the low LCG bits repeat too quickly
  function automatic word_t random_word();
    word_t hi, lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};
  endfunction

  // LUI encodings, so a word fetched past the final jump still decodes
  function automatic word_t fill_word(input int index);
    word_t addr;
    addr = word_t'(index) << 2;
    return (((addr * 32'h9e37_79b9) ^ 32'h2c1b_3c6d) & 32'hffff_ff80) | 32'h0000_0037;
  endfunction

  task automatic load_program();
    word_t word;
    model_init(reset_pc, mem_words);
    for (int i = 0; i < mem_words; i++) begin
      if (i < program_len) begin
        word = model_gen_inst(i, program_len, random_word());
      end else begin
        word = fill_word(i);
      end
      mem[i] = word;
      model_mem[i] = word;
    end
  endtask

  // memory side of APB, called once per cycle after the DUT has settled
  task automatic serve_apb();
    if (prev_setup && !(psel && penable)) begin
      report_problem("APB setup phase was not followed by an access phase");
    end
    prev_setup = psel && !penable;
    if (!psel) begin
      if (penable) begin
        report_problem("penable is high while psel is low");
      end
      pready = 1'b0;
    end else if (!penable) begin
      if (transfers == 0) begin
        check_word("paddr", paddr, reset_pc);
      end
      if (paddr >= 32'(mem_words * 4) || paddr[1:0] != 2'b00) begin
        report_problem("APB address is outside the memory or not word aligned");
      end
      xfer_addr = paddr;
      xfer_write = pwrite;
      xfer_wdata = pwdata;
      transfers++;
      waits_left = lcg_next() >> 30;
      pready = 1'b0;
    end else begin
      check_word("paddr", paddr, xfer_addr);
      check_flag("pwrite", pwrite, xfer_write);
      if (xfer_write) begin
        check_word("pwdata", pwdata, xfer_wdata);
      end
      if (waits_left > 0) begin
        waits_left--;
        pready = 1'b0;
      end else begin
        pready = 1'b1;
        pready_seen = 1'b1;
        if (xfer_write) begin
          mem[xfer_addr >> 2] = pwdata;
          write_addr_q.push_back(xfer_addr);
          write_data_q.push_back(pwdata);
        end else begin
          prdata = mem[xfer_addr >> 2];
        end
      end
    end
  endtask

  task automatic check_retire();
    word_t inst, exp_pc, exp_value, store_addr, store_data;
    reg_index_t exp_rd;
    if (!pready_seen) begin
      check_flag("retire_valid", retire_valid, 1'b0);
    end
    if (retire_valid && retire_count < retire_total) begin
      inst = model_mem[model_pc >> 2];
      // a store must already have gone out on APB with the model's address and data
      if (inst[6:0] == 7'b0100011) begin
        store_addr = model_regs[inst[19:15]] + {{20{inst[31]}}, inst[31:25], inst[11:7]};
        store_data = model_regs[inst[24:20]];
        if (write_addr_q.size() == 0) begin
          report_problem("a store retired without an APB write");
        end
        check_word("APB write address", write_addr_q.pop_front(), store_addr);
        check_word("APB write data", write_data_q.pop_front(), store_data);
      end
      model_step(exp_pc, exp_rd, exp_value);
      check_word("retire_pc", retire_pc, exp_pc);
      check_index("retire_rd", retire_rd, exp_rd);
      check_word("retire_value", retire_value, exp_value);
      retire_count++;
    end
  endtask

  task automatic wait_for_retire(input int target);
    int cycles;
    cycles = 0;
    while (retire_count < target) begin
      @(posedge clock);
      cycles++;
      if (retire_count < target && cycles >= wait_limit) begin
        report_problem("no instruction retired within 200 cycles");
      end
    end
  endtask

  task automatic compare_data_region();
    if (write_addr_q.size() != 0) begin
      report_problem("an APB write happened that no retired store accounts for");
    end
    for (int i = data_first; i <= data_last; i++) begin
      check_word($sformatf("memory word at 0x%h", i * 4), mem[i], model_mem[i]);
    end
  endtask

  // reset as the DUT saw it at the edge, then act once outputs are stable
  always begin
    @(posedge clock);
    dut_in_reset = reset;
    #2;
    if (!dut_in_reset) begin
      serve_apb();
      check_retire();
    end
  end

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    pready = 1'b0;
    prdata = '0;
    lcg_state = seed;
    prev_setup = 1'b0;
    pready_seen = 1'b0;
    transfers = 0;
    waits_left = 0;
    retire_count = 0;
    load_program();
    repeat (3) begin
      @(posedge clock);
      #2;
      if ($isunknown({psel, penable, retire_valid})) begin
        report_problem("APB or retire outputs are unknown during reset");
      end
      check_flag("psel", psel, 1'b0);
      check_flag("penable", penable, 1'b0);
      check_flag("retire_valid", retire_valid, 1'b0);
    end
    reset = 1'b0;
    for (int n = 1; n <= retire_total; n++) begin
      wait_for_retire(n);
    end
    compare_data_region();
    $display("All tests passed!");
    $finish;
  end

endmodule

/* all.f */
+incdir+include
src/rv_core_pkg.sv
src/register_file.sv
src/fetch_unit.sv
src/decode_unit.sv
src/execute_unit.sv
src/apb_arbiter.sv
src/rv_core_top.sv
tests/rv_core_tb.sv
